// ==== verilog.f ====
common/soc_bus_pkg.sv
interconnect/bus_arbiter.sv
interconnect/bus_interconnect.sv
design/bus_ram.sv
design/periph_gpio.sv
design/bus_stats.sv
design/soc_fabric_top.sv
tb/tb_soc_fabric.sv

// ==== Makefile ====
.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module tb_soc_fabric -f verilog.f

sim:
	verilator --binary --timing --top-module tb_soc_fabric -f verilog.f -o tb_soc_fabric
	./obj_dir/tb_soc_fabric > sim.log 2>&1; cat sim.log
	@if grep -q "TEST FAIL" sim.log; then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TEST PASS" sim.log; then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

// ==== tb/tb_soc_fabric.sv ====
`timescale 1ns/1ns

module tb_soc_fabric;

    localparam int          num_entries    = 21;
    localparam int          timeout_margin = 100;
    localparam int          cycle_limit    = num_entries * 10 + timeout_margin;
    localparam logic [31:0] rand_seed      = 32'ha7f1_f78f;

    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
        logic        we;
        logic [3:0]  be;
        logic [31:0] wdata;
        logic        rnd;      // Write data comes from $urandom
    } op_t;

    typedef struct packed {
        op_t         cpu;
        op_t         gpu;
        logic [15:0] gpio;
        logic        together; // Both masters start on the same edge
        logic [3:0]  cpu_lat;
        logic [3:0]  gpu_lat;
    } entry_t;

    logic                                                             clk;
    logic                                                             rst_n;
    logic [soc_bus_pkg::num_masters-1:0]                              master_req;
    logic [soc_bus_pkg::num_masters-1:0][soc_bus_pkg::addr_width-1:0] master_addr;
    logic [soc_bus_pkg::num_masters-1:0][soc_bus_pkg::data_width-1:0] master_wdata;
    logic [soc_bus_pkg::num_masters-1:0]                              master_we;
    logic [soc_bus_pkg::num_masters-1:0][soc_bus_pkg::be_width-1:0]   master_be;
    logic [soc_bus_pkg::num_masters-1:0][soc_bus_pkg::data_width-1:0] master_rdata;
    logic [soc_bus_pkg::num_masters-1:0]                              master_ready;
    logic [soc_bus_pkg::gpio_width-1:0]                               gpio_in;
    logic [soc_bus_pkg::gpio_width-1:0]                               gpio_out;

    // Reference model state
    logic [31:0] main_model [soc_bus_pkg::main_mem_words];
    logic [31:0] gpu_model [soc_bus_pkg::gpu_mem_words];
    logic [15:0] gpio_out_model;
    logic [15:0] gpio_in_now;
    logic [31:0] total_model;
    logic [31:0] cpu_model;
    logic [31:0] gpu_cnt_model;
    logic [31:0] conflict_model;
    entry_t      tests [num_entries];
    int          cycle_count;

    soc_fabric_top u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .master_req   (master_req),
        .master_addr  (master_addr),
        .master_wdata (master_wdata),
        .master_we    (master_we),
        .master_be    (master_be),
        .master_rdata (master_rdata),
        .master_ready (master_ready),
        .gpio_in      (gpio_in),
        .gpio_out     (gpio_out)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic op_t read_op(input logic [31:0] addr);
        return op_t'{1'b1, addr, 1'b0, 4'hF, 32'h0, 1'b0};
    endfunction

    function automatic op_t write_op(input logic [31:0] addr, input logic [3:0] be,
                                     input logic [31:0] data);
        return op_t'{1'b1, addr, 1'b1, be, data, 1'b0};
    endfunction

    function automatic op_t write_rand_op(input logic [31:0] addr, input logic [3:0] be);
        return op_t'{1'b1, addr, 1'b1, be, 32'h0, 1'b1};
    endfunction

    task automatic fill_tests();
        tests[0]  = '{write_rand_op(32'h0000_0040, 4'hF), '0, 16'h0000, 1'b0, 4'd3, 4'd0};
        tests[1]  = '{read_op(32'h0000_0040), '0, 16'h0000, 1'b0, 4'd3, 4'd0};
        tests[2]  = '{'0, write_rand_op(32'h0800_0100, 4'hF), 16'h0000, 1'b0, 4'd0, 4'd3};
        tests[3]  = '{'0, read_op(32'h0800_0100), 16'h0000, 1'b0, 4'd0, 4'd3};
        tests[4]  = '{write_op(32'h0000_0040, 4'b0011, 32'hDEAD_BEEF), '0,
                      16'h0000, 1'b0, 4'd3, 4'd0};
        tests[5]  = '{read_op(32'h0000_0440), '0, 16'h0000, 1'b0, 4'd3, 4'd0}; // Alias of 0x40
        tests[6]  = '{'0, write_op(32'h0800_0100, 4'b1100, 32'h1234_5678),
                      16'h0000, 1'b0, 4'd0, 4'd3};
        tests[7]  = '{read_op(32'h0800_0300), '0, 16'h0000, 1'b0, 4'd3, 4'd0};
        // Unmapped windows land in main memory
        tests[8]  = '{write_rand_op(32'h1000_0000, 4'hF), '0, 16'h0000, 1'b0, 4'd3, 4'd0};
        tests[9]  = '{'0, write_rand_op(32'h0D00_0008, 4'hF), 16'h0000, 1'b0, 4'd0, 4'd3};
        tests[10] = '{read_op(32'h0000_0000), read_op(32'h0000_0008), 16'h0000, 1'b1, 4'd3, 4'd7};
        tests[11] = '{write_rand_op(32'h0800_0010, 4'hF), read_op(32'h0800_0010),
                      16'h0000, 1'b1, 4'd3, 4'd7};
        tests[12] = '{write_op(32'h0C00_0000, 4'b0011, 32'hFFFF_A5C3), '0,
                      16'h3C96, 1'b0, 4'd3, 4'd0};
        tests[13] = '{'0, read_op(32'h0C00_0000), 16'h3C96, 1'b0, 4'd0, 4'd3};
        tests[14] = '{read_op(32'h0C00_0004), '0, 16'h5AA5, 1'b0, 4'd3, 4'd0};
        tests[15] = '{read_op(32'h0C00_0004), write_op(32'h0C00_0000, 4'b0010, 32'h0000_7700),
                      16'hC33C, 1'b0, 4'd3, 4'd3};
        // Counter reads, then a clear and reads again
        tests[16] = '{read_op(32'h0F00_0000), read_op(32'h0F00_0004), 16'h0000, 1'b1, 4'd3, 4'd7};
        tests[17] = '{read_op(32'h0F00_0008), read_op(32'h0F00_000C), 16'h0000, 1'b0, 4'd3, 4'd3};
        tests[18] = '{write_rand_op(32'h0F00_0010, 4'hF), '0, 16'h0000, 1'b0, 4'd3, 4'd0};
        tests[19] = '{read_op(32'h0F00_000C), read_op(32'h0F00_0000), 16'h0000, 1'b0, 4'd3, 4'd3};
        tests[20] = '{read_op(32'h0F00_0004), read_op(32'h0F00_0008), 16'h0000, 1'b1, 4'd3, 4'd7};
    endtask

    task automatic stop_run();
        $display("TEST FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] t=%0t %s expected %h actual %h", $time, name, expected, actual);
            stop_run();
        end
    endtask

    function automatic logic addr_in(input logic [31:0] addr, input logic [31:0] base,
                                     input logic [31:0] size);
        return (addr >= base) && ((addr - base) < size);
    endfunction

    function automatic int target_of(input logic [31:0] addr);
        if (addr_in(addr, soc_bus_pkg::gpu_mem_base, soc_bus_pkg::gpu_mem_size))
            return int'(soc_bus_pkg::tgt_gpu_mem);
        if (addr_in(addr, soc_bus_pkg::periph_base, soc_bus_pkg::periph_size))
            return int'(soc_bus_pkg::tgt_periph);
        if (addr_in(addr, soc_bus_pkg::config_base, soc_bus_pkg::config_size))
            return int'(soc_bus_pkg::tgt_config);
        return int'(soc_bus_pkg::tgt_main_mem);
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
                                                input logic [3:0] be);
        logic [31:0] word;
        word = old;
        for (int b = 0; b < 4; b++) begin
            if (be[b])
                word[b*8 +: 8] = data[b*8 +: 8];
        end
        return word;
    endfunction

    // Grant is counted first, so a counter read sees its own grant
    task automatic model_access(input int m, input op_t op, input logic conflict,
                                output logic [31:0] expected);
        int          tgt;
        int          idx;
        logic [31:0] off;
        expected    = '0;
        tgt         = target_of(op.addr);
        total_model = total_model + 1;
        if (m == 0)
            cpu_model = cpu_model + 1;
        else
            gpu_cnt_model = gpu_cnt_model + 1;
        if (conflict)
            conflict_model = conflict_model + 1;
        if (tgt == int'(soc_bus_pkg::tgt_gpu_mem)) begin
            idx = int'((op.addr >> 2) % soc_bus_pkg::gpu_mem_words); // Window aliases
            if (op.we)
                gpu_model[idx] = merge_bytes(gpu_model[idx], op.wdata, op.be);
            expected = gpu_model[idx];
        end else if (tgt == int'(soc_bus_pkg::tgt_periph)) begin
            off = op.addr - soc_bus_pkg::periph_base;
            if (op.we && off == 32'(soc_bus_pkg::gpio_out_off))
                gpio_out_model = merge_bytes({16'h0, gpio_out_model}, op.wdata, op.be & 4'b0011);
            if (off == 32'(soc_bus_pkg::gpio_out_off))
                expected = {16'h0, gpio_out_model};
            else if (off == 32'(soc_bus_pkg::gpio_in_off))
                expected = {16'h0, gpio_in_now};
        end else if (tgt == int'(soc_bus_pkg::tgt_config)) begin
            off = op.addr - soc_bus_pkg::config_base;
            if (op.we && off == 32'(soc_bus_pkg::cfg_clear_off)) begin
                total_model    = '0;
                cpu_model      = '0;
                gpu_cnt_model  = '0;
                conflict_model = '0;
            end
            if (off == 32'(soc_bus_pkg::cfg_total_off))         expected = total_model;
            else if (off == 32'(soc_bus_pkg::cfg_cpu_off))      expected = cpu_model;
            else if (off == 32'(soc_bus_pkg::cfg_gpu_off))      expected = gpu_cnt_model;
            else if (off == 32'(soc_bus_pkg::cfg_conflict_off)) expected = conflict_model;
        end else begin
            idx = int'((op.addr >> 2) % soc_bus_pkg::main_mem_words);
            if (op.we)
                main_model[idx] = merge_bytes(main_model[idx], op.wdata, op.be);
            expected = main_model[idx];
        end
    endtask

    // Holds the request until ready, latency counted from the first sampling edge
    task automatic run_master(input int m, input op_t op, output logic [31:0] rdata,
                              output int lat);
        int waits;
        waits = 0;
        @(posedge clk);
        master_req[m]   <= 1'b1;
        master_addr[m]  <= op.addr;
        master_wdata[m] <= op.wdata;
        master_we[m]    <= op.we;
        master_be[m]    <= op.be;
        do begin
            @(negedge clk);
            waits++;
        end while (master_ready[m] !== 1'b1);
        rdata = master_rdata[m];
        @(posedge clk);
        master_req[m] <= 1'b0;
        lat = waits - 1;
    endtask

    initial begin
        cycle_count = 0;
        forever begin
            @(posedge clk);
            cycle_count++;
            if (cycle_count > cycle_limit) begin
                $display("Timeout: no master_ready arrived within %0d cycles", cycle_limit);
                stop_run();
            end
        end
    end

    initial begin
        logic [31:0] seed_ret;
        logic [31:0] cpu_rdata;
        logic [31:0] gpu_rdata;
        logic [31:0] exp_rdata;
        int          cpu_lat;
        int          gpu_lat;
        op_t         cpu_op;
        op_t         gpu_op;
        rst_n          = 1'b0;
        master_req     = '0;
        master_addr    = '0;
        master_wdata   = '0;
        master_we      = '0;
        master_be      = '0;
        gpio_in        = '0;
        gpio_out_model = '0;
        gpio_in_now    = '0;
        total_model    = '0;
        cpu_model      = '0;
        gpu_cnt_model  = '0;
        conflict_model = '0;
        seed_ret       = $urandom(rand_seed);
        fill_tests();
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < num_entries; i++) begin
            cpu_op = tests[i].cpu;
            gpu_op = tests[i].gpu;
            if (cpu_op.rnd) cpu_op.wdata = $urandom();
            if (gpu_op.rnd) gpu_op.wdata = $urandom();
            @(posedge clk);
            gpio_in     <= tests[i].gpio;
            gpio_in_now = tests[i].gpio;
            repeat (2) @(posedge clk); // gpio_in settles into its register
            if (tests[i].together && cpu_op.valid && gpu_op.valid) begin
                fork
                    run_master(0, cpu_op, cpu_rdata, cpu_lat);
                    run_master(1, gpu_op, gpu_rdata, gpu_lat);
                join
            end else begin
                if (cpu_op.valid) run_master(0, cpu_op, cpu_rdata, cpu_lat);
                if (gpu_op.valid) run_master(1, gpu_op, gpu_rdata, gpu_lat);
            end
            // CPU always finishes first
            if (cpu_op.valid) begin
                model_access(0, cpu_op, tests[i].together && gpu_op.valid, exp_rdata);
                if (!cpu_op.we) check("master_rdata[0]", exp_rdata, cpu_rdata);
                check("cpu latency", 32'(tests[i].cpu_lat), 32'(cpu_lat));
            end
            if (gpu_op.valid) begin
                model_access(1, gpu_op, 1'b0, exp_rdata);
                if (!gpu_op.we) check("master_rdata[1]", exp_rdata, gpu_rdata);
                check("gpu latency", 32'(tests[i].gpu_lat), 32'(gpu_lat));
            end
            @(negedge clk);
            check("gpio_out", {16'h0, gpio_out_model}, {16'h0, gpio_out});
        end
        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== design/soc_fabric_top.sv ====
`timescale 1ns/1ns

module soc_fabric_top (
    input  logic                                                             clk,
    input  logic                                                             rst_n,
    input  logic [soc_bus_pkg::num_masters-1:0]                              master_req,
    input  logic [soc_bus_pkg::num_masters-1:0][soc_bus_pkg::addr_width-1:0] master_addr,
    input  logic [soc_bus_pkg::num_masters-1:0][soc_bus_pkg::data_width-1:0] master_wdata,
    input  logic [soc_bus_pkg::num_masters-1:0]                              master_we,
    input  logic [soc_bus_pkg::num_masters-1:0][soc_bus_pkg::be_width-1:0]   master_be,
    output logic [soc_bus_pkg::num_masters-1:0][soc_bus_pkg::data_width-1:0] master_rdata,
    output logic [soc_bus_pkg::num_masters-1:0]                              master_ready,
    input  logic [soc_bus_pkg::gpio_width-1:0]                               gpio_in,
    output logic [soc_bus_pkg::gpio_width-1:0]                               gpio_out
);

    logic [soc_bus_pkg::num_targets-1:0]                              slave_req;
    logic [soc_bus_pkg::num_targets-1:0][soc_bus_pkg::addr_width-1:0] slave_addr;
    logic [soc_bus_pkg::num_targets-1:0][soc_bus_pkg::data_width-1:0] slave_wdata;
    logic [soc_bus_pkg::num_targets-1:0]                              slave_we;
    logic [soc_bus_pkg::num_targets-1:0][soc_bus_pkg::be_width-1:0]   slave_be;
    logic [soc_bus_pkg::num_targets-1:0][soc_bus_pkg::data_width-1:0] slave_rdata;
    logic [soc_bus_pkg::num_targets-1:0]                              slave_ready;
    logic                                                             grant_valid;
    logic [soc_bus_pkg::master_id_width-1:0]                          grant_master;
    logic                                                             grant_conflict;

    bus_interconnect u_interconnect (
        .clk            (clk),
        .rst_n          (rst_n),
        .master_req     (master_req),
        .master_addr    (master_addr),
        .master_wdata   (master_wdata),
        .master_we      (master_we),
        .master_be      (master_be),
        .master_rdata   (master_rdata),
        .master_ready   (master_ready),
        .slave_req      (slave_req),
        .slave_addr     (slave_addr),
        .slave_wdata    (slave_wdata),
        .slave_we       (slave_we),
        .slave_be       (slave_be),
        .slave_rdata    (slave_rdata),
        .slave_ready    (slave_ready),
        .grant_valid    (grant_valid),
        .grant_master   (grant_master),
        .grant_conflict (grant_conflict)
    );

    bus_ram #(.words(soc_bus_pkg::main_mem_words)) u_main_mem (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (slave_req[soc_bus_pkg::tgt_main_mem]),
        .addr  (slave_addr[soc_bus_pkg::tgt_main_mem]),
        .wdata (slave_wdata[soc_bus_pkg::tgt_main_mem]),
        .we    (slave_we[soc_bus_pkg::tgt_main_mem]),
        .be    (slave_be[soc_bus_pkg::tgt_main_mem]),
        .rdata (slave_rdata[soc_bus_pkg::tgt_main_mem]),
        .ready (slave_ready[soc_bus_pkg::tgt_main_mem])
    );

    bus_ram #(.words(soc_bus_pkg::gpu_mem_words)) u_gpu_mem (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (slave_req[soc_bus_pkg::tgt_gpu_mem]),
        .addr  (slave_addr[soc_bus_pkg::tgt_gpu_mem]),
        .wdata (slave_wdata[soc_bus_pkg::tgt_gpu_mem]),
        .we    (slave_we[soc_bus_pkg::tgt_gpu_mem]),
        .be    (slave_be[soc_bus_pkg::tgt_gpu_mem]),
        .rdata (slave_rdata[soc_bus_pkg::tgt_gpu_mem]),
        .ready (slave_ready[soc_bus_pkg::tgt_gpu_mem])
    );

    periph_gpio u_gpio (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (slave_req[soc_bus_pkg::tgt_periph]),
        .addr     (slave_addr[soc_bus_pkg::tgt_periph]),
        .wdata    (slave_wdata[soc_bus_pkg::tgt_periph]),
        .we       (slave_we[soc_bus_pkg::tgt_periph]),
        .be       (slave_be[soc_bus_pkg::tgt_periph]),
        .gpio_in  (gpio_in),
        .rdata    (slave_rdata[soc_bus_pkg::tgt_periph]),
        .ready    (slave_ready[soc_bus_pkg::tgt_periph]),
        .gpio_out (gpio_out)
    );

    // Grant events come straight from the arbiter
    bus_stats u_stats (
        .clk            (clk),
        .rst_n          (rst_n),
        .req            (slave_req[soc_bus_pkg::tgt_config]),
        .addr           (slave_addr[soc_bus_pkg::tgt_config]),
        .wdata          (slave_wdata[soc_bus_pkg::tgt_config]),
        .we             (slave_we[soc_bus_pkg::tgt_config]),
        .grant_valid    (grant_valid),
        .grant_master   (grant_master),
        .grant_conflict (grant_conflict),
        .rdata          (slave_rdata[soc_bus_pkg::tgt_config]),
        .ready          (slave_ready[soc_bus_pkg::tgt_config])
    );

endmodule

// ==== design/bus_stats.sv ====
`timescale 1ns/1ns

module bus_stats (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    req,
    input  logic [soc_bus_pkg::addr_width-1:0]      addr,
    input  logic [soc_bus_pkg::data_width-1:0]      wdata,
    input  logic                                    we,
    input  logic                                    grant_valid,
    input  logic [soc_bus_pkg::master_id_width-1:0] grant_master,
    input  logic                                    grant_conflict,
    output logic [soc_bus_pkg::data_width-1:0]      rdata,
    output logic                                    ready
);

    logic [soc_bus_pkg::data_width-1:0] total_cnt;
    logic [soc_bus_pkg::data_width-1:0] cpu_cnt;
    logic [soc_bus_pkg::data_width-1:0] gpu_cnt;
    logic [soc_bus_pkg::data_width-1:0] conflict_cnt;
    logic                               clear;

    // Any write to the clear offset zeroes the counters
    assign clear = req && we && (addr[7:0] == soc_bus_pkg::cfg_clear_off);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            total_cnt    <= '0;
            cpu_cnt      <= '0;
            gpu_cnt      <= '0;
            conflict_cnt <= '0;
            ready        <= 1'b0;
        end else begin
            ready <= req;
            if (clear) begin // Beats a same-cycle grant
                total_cnt    <= '0;
                cpu_cnt      <= '0;
                gpu_cnt      <= '0;
                conflict_cnt <= '0;
            end else if (grant_valid) begin
                total_cnt <= total_cnt + 1'b1;
                if (grant_master == '0)
                    cpu_cnt <= cpu_cnt + 1'b1;
                else
                    gpu_cnt <= gpu_cnt + 1'b1;
                if (grant_conflict)
                    conflict_cnt <= conflict_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            case (addr[7:0])
                soc_bus_pkg::cfg_total_off:    rdata <= total_cnt;
                soc_bus_pkg::cfg_cpu_off:      rdata <= cpu_cnt;
                soc_bus_pkg::cfg_gpu_off:      rdata <= gpu_cnt;
                soc_bus_pkg::cfg_conflict_off: rdata <= conflict_cnt;
                default:                       rdata <= '0;
            endcase
        end
    end

endmodule

// ==== design/periph_gpio.sv ====
`timescale 1ns/1ns

module periph_gpio (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                req,
    input  logic [soc_bus_pkg::addr_width-1:0]  addr,
    input  logic [soc_bus_pkg::data_width-1:0]  wdata,
    input  logic                                we,
    input  logic [soc_bus_pkg::be_width-1:0]    be,
    input  logic [soc_bus_pkg::gpio_width-1:0]  gpio_in,
    output logic [soc_bus_pkg::data_width-1:0]  rdata,
    output logic                                ready,
    output logic [soc_bus_pkg::gpio_width-1:0]  gpio_out
);

    logic [soc_bus_pkg::gpio_width-1:0] gpio_in_q;
    logic                               hit_out;
    logic                               hit_in;

    assign hit_out = addr[7:0] == soc_bus_pkg::gpio_out_off;
    assign hit_in  = addr[7:0] == soc_bus_pkg::gpio_in_off;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gpio_out  <= '0;
            gpio_in_q <= '0;
            ready     <= 1'b0;
        end else begin
            gpio_in_q <= gpio_in; // Sampled every cycle
            ready     <= req;
            if (req && we && hit_out) begin
                for (int b = 0; b < soc_bus_pkg::gpio_width / 8; b++) begin
                    if (be[b])
                        gpio_out[b*8 +: 8] <= wdata[b*8 +: 8];
                end
            end
        end
    end

    // Unknown offsets read as zero
    always_ff @(posedge clk) begin
        if (req) begin
            if (hit_out)
                rdata <= soc_bus_pkg::data_width'(gpio_out);
            else if (hit_in)
                rdata <= soc_bus_pkg::data_width'(gpio_in_q);
            else
                rdata <= '0;
        end
    end

endmodule

// ==== design/bus_ram.sv ====
`timescale 1ns/1ns

module bus_ram #(
    parameter int words = 256
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                req,
    input  logic [soc_bus_pkg::addr_width-1:0]  addr,
    input  logic [soc_bus_pkg::data_width-1:0]  wdata,
    input  logic                                we,
    input  logic [soc_bus_pkg::be_width-1:0]    be,
    output logic [soc_bus_pkg::data_width-1:0]  rdata,
    output logic                                ready
);

    localparam int idx_width = (words > 1) ? $clog2(words) : 1;

    logic [soc_bus_pkg::data_width-1:0] mem [words];
    logic [idx_width-1:0]               idx;

    // Upper address bits are dropped, so the window aliases
    assign idx = addr[2 +: idx_width];

    always_ff @(posedge clk) begin
        if (req) begin
            if (we) begin
                for (int b = 0; b < soc_bus_pkg::be_width; b++) begin
                    if (be[b])
                        mem[idx][b*8 +: 8] <= wdata[b*8 +: 8];
                end
            end
            rdata <= mem[idx]; // Old word on a write, ignored by the master
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            ready <= 1'b0;
        else
            ready <= req;
    end

endmodule

// ==== interconnect/bus_interconnect.sv ====
`timescale 1ns/1ns

module bus_interconnect (
    input  logic                                                             clk,
    input  logic                                                             rst_n,
    input  logic [soc_bus_pkg::num_masters-1:0]                              master_req,
    input  logic [soc_bus_pkg::num_masters-1:0][soc_bus_pkg::addr_width-1:0] master_addr,
    input  logic [soc_bus_pkg::num_masters-1:0][soc_bus_pkg::data_width-1:0] master_wdata,
    input  logic [soc_bus_pkg::num_masters-1:0]                              master_we,
    input  logic [soc_bus_pkg::num_masters-1:0][soc_bus_pkg::be_width-1:0]   master_be,
    output logic [soc_bus_pkg::num_masters-1:0][soc_bus_pkg::data_width-1:0] master_rdata,
    output logic [soc_bus_pkg::num_masters-1:0]                              master_ready,
    output logic [soc_bus_pkg::num_targets-1:0]                              slave_req,
    output logic [soc_bus_pkg::num_targets-1:0][soc_bus_pkg::addr_width-1:0] slave_addr,
    output logic [soc_bus_pkg::num_targets-1:0][soc_bus_pkg::data_width-1:0] slave_wdata,
    output logic [soc_bus_pkg::num_targets-1:0]                              slave_we,
    output logic [soc_bus_pkg::num_targets-1:0][soc_bus_pkg::be_width-1:0]   slave_be,
    input  logic [soc_bus_pkg::num_targets-1:0][soc_bus_pkg::data_width-1:0] slave_rdata,
    input  logic [soc_bus_pkg::num_targets-1:0]                              slave_ready,
    output logic                                                             grant_valid,
    output logic [soc_bus_pkg::master_id_width-1:0]                          grant_master,
    output logic                                                             grant_conflict
);

    logic [soc_bus_pkg::addr_width-1:0]      addr_q;
    logic [soc_bus_pkg::data_width-1:0]      wdata_q;
    logic                                    we_q;
    logic [soc_bus_pkg::be_width-1:0]        be_q;
    logic [soc_bus_pkg::master_id_width-1:0] master_q;
    logic [soc_bus_pkg::target_id_width-1:0] target_q;
    logic                                    req_q;    // Slave request pulse
    logic                                    active_q; // Transaction in flight
    logic                                    done;

    // Bases are aligned to their sizes, so a mask compare is enough
    function automatic logic in_window(input logic [soc_bus_pkg::addr_width-1:0] addr,
                                       input logic [soc_bus_pkg::addr_width-1:0] base,
                                       input logic [soc_bus_pkg::addr_width-1:0] size);
        return (addr & ~(size - 1'b1)) == base;
    endfunction

    function automatic logic [soc_bus_pkg::target_id_width-1:0] decode(
        input logic [soc_bus_pkg::addr_width-1:0] addr
    );
        if (in_window(addr, soc_bus_pkg::gpu_mem_base, soc_bus_pkg::gpu_mem_size))
            return soc_bus_pkg::tgt_gpu_mem;
        if (in_window(addr, soc_bus_pkg::periph_base, soc_bus_pkg::periph_size))
            return soc_bus_pkg::tgt_periph;
        if (in_window(addr, soc_bus_pkg::config_base, soc_bus_pkg::config_size))
            return soc_bus_pkg::tgt_config;
        return soc_bus_pkg::tgt_main_mem; // Main window and unmapped space
    endfunction

    bus_arbiter u_arbiter (
        .clk            (clk),
        .rst_n          (rst_n),
        .master_req     (master_req),
        .done           (done),
        .grant_valid    (grant_valid),
        .grant_master   (grant_master),
        .grant_conflict (grant_conflict)
    );

    // Winner's fields, captured in the grant cycle
    always_ff @(posedge clk) begin
        if (grant_valid) begin
            addr_q  <= master_addr[grant_master];
            wdata_q <= master_wdata[grant_master];
            we_q    <= master_we[grant_master];
            be_q    <= master_be[grant_master];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_q    <= 1'b0;
            active_q <= 1'b0;
            master_q <= '0;
            target_q <= soc_bus_pkg::tgt_main_mem;
        end else begin
            req_q <= grant_valid;
            if (grant_valid) begin
                active_q <= 1'b1;
                master_q <= grant_master;
                target_q <= decode(master_addr[grant_master]);
            end else if (done) begin
                active_q <= 1'b0;
            end
        end
    end

    assign done = active_q && slave_ready[target_q];

    // Request goes to one target, the fields are shared by all
    for (genvar t = 0; t < soc_bus_pkg::num_targets; t++) begin : g_target
        assign slave_req[t]   = req_q && (target_q == soc_bus_pkg::target_id_width'(t));
        assign slave_addr[t]  = addr_q;
        assign slave_wdata[t] = wdata_q;
        assign slave_we[t]    = we_q;
        assign slave_be[t]    = be_q;
    end

    for (genvar m = 0; m < soc_bus_pkg::num_masters; m++) begin : g_master
        logic owner;
        assign owner           = active_q && (master_q == soc_bus_pkg::master_id_width'(m));
        assign master_ready[m] = owner && slave_ready[target_q];
        assign master_rdata[m] = owner ? slave_rdata[target_q] : '0;
    end

endmodule

// ==== interconnect/bus_arbiter.sv ====
`timescale 1ns/1ns

module bus_arbiter (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic [soc_bus_pkg::num_masters-1:0]     master_req,
    input  logic                                    done,
    output logic                                    grant_valid,
    output logic [soc_bus_pkg::master_id_width-1:0] grant_master,
    output logic                                    grant_conflict
);

    typedef enum logic [1:0] {
        st_idle,
        st_busy,
        st_turn
    } state_t;

    state_t                                  state;
    logic [soc_bus_pkg::master_id_width-1:0] pick;
    logic                                    any_req;
    logic                                    multi_req;

    // Lowest index wins, so the CPU beats the GPU
    always_comb begin
        pick = '0;
        for (int i = soc_bus_pkg::num_masters - 1; i >= 0; i--) begin
            if (master_req[i])
                pick = soc_bus_pkg::master_id_width'(i);
        end
    end

    assign any_req   = |master_req;
    assign multi_req = (master_req & (master_req - 1'b1)) != '0; // More than one bit set

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state          <= st_idle;
            grant_valid    <= 1'b0;
            grant_master   <= '0;
            grant_conflict <= 1'b0;
        end else begin
            grant_valid    <= 1'b0; // One-cycle event pulses
            grant_conflict <= 1'b0;
            case (state)
                // The turnaround cycle lets the finished master drop its request
                st_idle, st_turn: begin
                    if (any_req) begin
                        grant_valid    <= 1'b1;
                        grant_master   <= pick;
                        grant_conflict <= multi_req;
                        state          <= st_busy;
                    end else begin
                        state <= st_idle;
                    end
                end
                st_busy: if (done) state <= st_turn;
                default: state <= st_idle;
            endcase
        end
    end

endmodule

// ==== common/soc_bus_pkg.sv ====
package soc_bus_pkg;

    localparam int addr_width = 32;
    localparam int data_width = 32;
    localparam int be_width   = 4;

    // Master 0 is the CPU, master 1 the GPU
    localparam int num_masters = 2;
    localparam int num_targets = 4;

    localparam int master_id_width = (num_masters > 1) ? $clog2(num_masters) : 1;
    localparam int target_id_width = (num_targets > 1) ? $clog2(num_targets) : 1;

    // Address windows, each base aligned to its size
    localparam logic [addr_width-1:0] main_mem_base = 32'h0000_0000;
    localparam logic [addr_width-1:0] main_mem_size = 32'h0800_0000;
    localparam logic [addr_width-1:0] gpu_mem_base  = 32'h0800_0000;
    localparam logic [addr_width-1:0] gpu_mem_size  = 32'h0400_0000;
    localparam logic [addr_width-1:0] periph_base   = 32'h0C00_0000;
    localparam logic [addr_width-1:0] periph_size   = 32'h0100_0000;
    localparam logic [addr_width-1:0] config_base   = 32'h0F00_0000;
    localparam logic [addr_width-1:0] config_size   = 32'h0100_0000;

    localparam logic [target_id_width-1:0] tgt_main_mem = 2'd0;
    localparam logic [target_id_width-1:0] tgt_gpu_mem  = 2'd1;
    localparam logic [target_id_width-1:0] tgt_periph   = 2'd2;
    localparam logic [target_id_width-1:0] tgt_config   = 2'd3;

    localparam int main_mem_words = 256;
    localparam int gpu_mem_words  = 128;

    // Register offsets inside the config and GPIO windows
    localparam logic [7:0] cfg_total_off    = 8'h00;
    localparam logic [7:0] cfg_cpu_off      = 8'h04;
    localparam logic [7:0] cfg_gpu_off      = 8'h08;
    localparam logic [7:0] cfg_conflict_off = 8'h0C;
    localparam logic [7:0] cfg_clear_off    = 8'h10;
    localparam logic [7:0] gpio_out_off     = 8'h00;
    localparam logic [7:0] gpio_in_off      = 8'h04;

    localparam int gpio_width = 16;

endpackage
